/* hdl/soc_pkg.sv */
package soc_pkg;

  // Two harts share one CLINT.
  localparam int clint_contexts = 1;
  localparam int num_harts = 2 ** clint_contexts;

  localparam logic [31:0] clint_base_address = 32'h0200_0000;
  localparam logic [31:0] clint_top_address = 32'h0200_C000; // Exclusive.

  localparam logic [31:0] msip_offset = 32'h0000_0000;
  localparam logic [31:0] mtimecmp_offset = 32'h0000_4000;
  localparam logic [31:0] mtime_offset = 32'h0000_BFF8;

  localparam int bram_depth = 1024; // 32-bit words.
  localparam int bram_addr_bits = $clog2(bram_depth);

  typedef struct packed {
    logic        valid;
    logic        instr;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
  } mem_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        ready;
  } mem_rsp_t;

  typedef enum logic {
    tgt_bram,
    tgt_clint
  } target_e;

  typedef enum logic [2:0] {
    reg_msip,
    reg_mtimecmp_lo,
    reg_mtimecmp_hi,
    reg_mtime_lo,
    reg_mtime_hi,
    reg_none
  } clint_reg_e;

endpackage

/* hdl/mem_decoder.sv */
`timescale 1ns/1ns

module mem_decoder import soc_pkg::*; (
  input  mem_req_t cpu_req,
  output mem_rsp_t cpu_rsp,
  output mem_req_t bram_req,
  input  mem_rsp_t bram_rsp,
  output mem_req_t clint_req,
  input  mem_rsp_t clint_rsp
);

  target_e target;

  always_comb begin
    if (cpu_req.addr >= clint_base_address && cpu_req.addr < clint_top_address) begin
      target = tgt_clint;
    end else begin
      target = tgt_bram;
    end
  end

  always_comb begin
    bram_req = cpu_req;
    bram_req.valid = cpu_req.valid && (target == tgt_bram);

    clint_req = cpu_req;
    clint_req.valid = cpu_req.valid && (target == tgt_clint);
    clint_req.addr = cpu_req.addr ^ clint_base_address; // Offset inside the window.
  end

  // RAM wins if both ever answered; they never should.
  always_comb begin
    if (bram_rsp.ready) begin
      cpu_rsp = bram_rsp;
    end else if (clint_rsp.ready) begin
      cpu_rsp = clint_rsp;
    end else begin
      cpu_rsp = '0;
    end
  end

  // Registered readies follow the one-hot valids.
  always_comb begin
    assert (!((bram_rsp.ready & clint_rsp.ready) === 1'b1))
      else $error("mem_decoder: both slaves ready");
  end

endmodule

/* hdl/bram.sv */
`timescale 1ns/1ns

module bram import soc_pkg::*; (
  input  logic     clk,
  input  logic     arst_n,
  input  mem_req_t req,
  output mem_rsp_t rsp
);

  logic [31:0] mem [bram_depth];
  logic [bram_addr_bits-1:0] index;
  logic [31:0] rdata_q;
  logic ready_q;
  logic access;
  logic write;

  assign index = req.addr[bram_addr_bits+1:2]; // Upper bits alias.
  assign access = req.valid && !ready_q;
  assign write = access && !req.instr;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= access;
    end
  end

  // Contents survive reset.
  always_ff @(posedge clk) begin
    if (write) begin
      for (int i = 0; i < 4; i++) begin
        if (req.wstrb[i]) begin
          mem[index][8*i +: 8] <= req.wdata[8*i +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (access) begin
      rdata_q <= mem[index]; // Old word on a write.
    end
  end

  assign rsp.rdata = rdata_q;
  assign rsp.ready = ready_q;

  // A selected request must carry defined control fields.
  assert property (@(posedge clk) disable iff (!arst_n)
                   req.valid |-> !$isunknown({req.instr, req.addr, req.wstrb}))
    else $error("bram: request with unknown control fields");

endmodule

/* hdl/clint.sv */
`timescale 1ns/1ns

module clint import soc_pkg::*; (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 rtc,
  input  mem_req_t             req,
  output mem_rsp_t             rsp,
  output logic [num_harts-1:0] msip,
  output logic [num_harts-1:0] mtip,
  output logic [63:0]          mtime
);

  clint_reg_e sel;
  logic [clint_contexts-1:0] hart;
  logic [63:0] mtimecmp [num_harts];
  logic [1:0] rtc_sync;
  logic rtc_q;
  logic rtc_rise;
  logic [31:0] rdata_d;
  logic [31:0] rdata_q;
  logic ready_q;
  logic access;
  logic write;

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0] strb);
    logic [31:0] result;
    result = old_word;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) begin
        result[8*i +: 8] = new_word[8*i +: 8];
      end
    end
    return result;
  endfunction

  assign access = req.valid && !ready_q;
  assign write = access && !req.instr;

  always_comb begin
    sel = reg_none;
    hart = '0;
    if (req.addr >= msip_offset && req.addr < msip_offset + 4 * num_harts) begin
      sel = reg_msip;
      hart = req.addr[2 +: clint_contexts]; // One word per hart.
    end else if (req.addr >= mtimecmp_offset && req.addr < mtimecmp_offset + 8 * num_harts) begin
      sel = req.addr[2] ? reg_mtimecmp_hi : reg_mtimecmp_lo;
      hart = req.addr[3 +: clint_contexts];
    end else if (req.addr == mtime_offset) begin
      sel = reg_mtime_lo;
    end else if (req.addr == mtime_offset + 32'd4) begin
      sel = reg_mtime_hi;
    end
  end

  always_comb begin
    case (sel)
      reg_msip:        rdata_d = {31'b0, msip[hart]};
      reg_mtimecmp_lo: rdata_d = mtimecmp[hart][31:0];
      reg_mtimecmp_hi: rdata_d = mtimecmp[hart][63:32];
      reg_mtime_lo:    rdata_d = mtime[31:0];
      reg_mtime_hi:    rdata_d = mtime[63:32];
      default:         rdata_d = '0; // Unmapped offsets read zero.
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ready_q <= 1'b0;
      rtc_sync <= '0;
      rtc_q <= 1'b0;
      msip <= '0;
    end else begin
      ready_q <= access;
      rtc_sync <= {rtc_sync[0], rtc};
      rtc_q <= rtc_sync[1];
      if (write && sel == reg_msip && req.wstrb[0]) begin
        msip[hart] <= req.wdata[0];
      end
    end
  end

  assign rtc_rise = rtc_sync[1] && !rtc_q;

  // Software write beats the tick.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mtime <= '0;
    end else if (write && sel == reg_mtime_lo) begin
      mtime[31:0] <= merge_bytes(mtime[31:0], req.wdata, req.wstrb);
    end else if (write && sel == reg_mtime_hi) begin
      mtime[63:32] <= merge_bytes(mtime[63:32], req.wdata, req.wstrb);
    end else if (rtc_rise) begin
      mtime <= mtime + 64'd1;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < num_harts; i++) begin
        mtimecmp[i] <= '1;
      end
    end else if (write && sel == reg_mtimecmp_lo) begin
      mtimecmp[hart][31:0] <= merge_bytes(mtimecmp[hart][31:0], req.wdata, req.wstrb);
    end else if (write && sel == reg_mtimecmp_hi) begin
      mtimecmp[hart][63:32] <= merge_bytes(mtimecmp[hart][63:32], req.wdata, req.wstrb);
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mtip <= '0;
    end else begin
      for (int i = 0; i < num_harts; i++) begin
        mtip[i] <= (mtime >= mtimecmp[i]);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (access) begin
      rdata_q <= rdata_d;
    end
  end

  assign rsp.rdata = rdata_q;
  assign rsp.ready = ready_q;

  // Requests arrive as offsets inside the window.
  assert property (@(posedge clk) disable iff (!arst_n)
                   req.valid |-> req.addr < (clint_top_address - clint_base_address))
    else $error("clint: request address is not an offset inside the window");

endmodule

/* hdl/soc.sv */
`timescale 1ns/1ns

module soc import soc_pkg::*; (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 rtc,
  input  mem_req_t             cpu_req,
  output mem_rsp_t             cpu_rsp,
  output logic [num_harts-1:0] msip,
  output logic [num_harts-1:0] mtip,
  output logic [63:0]          mtime
);

  mem_req_t bram_req;
  mem_rsp_t bram_rsp;
  mem_req_t clint_req;
  mem_rsp_t clint_rsp;

  mem_decoder mem_decoder_i (
    .cpu_req   (cpu_req),
    .cpu_rsp   (cpu_rsp),
    .bram_req  (bram_req),
    .bram_rsp  (bram_rsp),
    .clint_req (clint_req),
    .clint_rsp (clint_rsp)
  );

  bram bram_i (
    .clk    (clk),
    .arst_n (arst_n),
    .req    (bram_req),
    .rsp    (bram_rsp)
  );

  clint clint_i (
    .clk    (clk),
    .arst_n (arst_n),
    .rtc    (rtc),
    .req    (clint_req),
    .rsp    (clint_rsp),
    .msip   (msip),
    .mtip   (mtip),
    .mtime  (mtime)
  );

endmodule

/* testbench/soc_tb.sv */
`timescale 1ns/1ns

module soc_tb import soc_pkg::*; ();

  logic clk;
  logic arst_n;
  logic rtc;
  mem_req_t cpu_req;
  mem_rsp_t cpu_rsp;
  logic [num_harts-1:0] msip;
  logic [num_harts-1:0] mtip;
  logic [63:0] mtime;

  logic [31:0] seed;
  logic [31:0] ram_model [bram_depth];
  int errors;
  int tests_passed;
  int tests_failed;
  int rtc_rises;

  soc soc_i (
    .clk     (clk),
    .arst_n  (arst_n),
    .rtc     (rtc),
    .cpu_req (cpu_req),
    .cpu_rsp (cpu_rsp),
    .msip    (msip),
    .mtip    (mtip),
    .mtime   (mtime)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    rtc = 1'b0;
    rtc_rises = 0;
    forever begin
      repeat (5) @(negedge clk);
      rtc = ~rtc;
      if (rtc) begin
        rtc_rises++;
      end
    end
  end

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic logic [bram_addr_bits-1:0] ram_index(input logic [31:0] addr);
    return bram_addr_bits'((addr / 32'd4) % bram_depth);
  endfunction

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (actual !== expected) begin
      $display("FAIL %0t %s expected %h actual %h", $time, name, expected, actual);
      errors++;
    end
  endtask

  task automatic transfer(input logic instr, input logic [31:0] addr, input logic [31:0] wdata,
                          input logic [3:0] wstrb, output logic [31:0] rdata);
    int cycles;
    @(negedge clk);
    cpu_req.valid = 1'b1;
    cpu_req.instr = instr;
    cpu_req.addr = addr;
    cpu_req.wdata = wdata;
    cpu_req.wstrb = wstrb;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (!cpu_rsp.ready && cycles < 16);
    if (cpu_rsp.ready) begin
      rdata = cpu_rsp.rdata;
    end else begin
      $display("ERROR %0t: bus gave no ready for address %h", $time, addr);
      errors++;
      rdata = 'x;
    end
    cpu_req = '0;
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, input logic instr);
    logic [31:0] unused;
    transfer(instr, addr, data, strb, unused);
  endtask

  task automatic bus_read(input logic [31:0] addr, input logic instr, output logic [31:0] data);
    transfer(instr, addr, 32'h0, 4'h0, data);
  endtask

  task automatic finish_test(input string name, input int errors_before);
    if (errors == errors_before) begin
      tests_passed++;
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, errors - errors_before);
    end
  endtask

  task automatic test_ram_readback();
    logic [31:0] addrs [16];
    logic [31:0] data;
    logic [31:0] rdata;
    int start;
    start = errors;
    for (int i = 0; i < 16; i++) begin
      addrs[i] = next_rand() & 32'h01ff_fffc; // Below the CLINT window.
      data = next_rand();
      bus_write(addrs[i], data, 4'hf, 1'b0);
      ram_model[ram_index(addrs[i])] = data;
    end
    for (int i = 0; i < 16; i++) begin
      bus_read(addrs[i], 1'b0, rdata);
      check("cpu_rsp.rdata", ram_model[ram_index(addrs[i])], rdata);
    end
    finish_test("ram readback", start);
  endtask

  task automatic test_strobes_fetch();
    logic [31:0] addr;
    logic [31:0] expected;
    logic [31:0] data;
    logic [31:0] rdata;
    int start;
    start = errors;
    addr = 32'h0000_0100;
    expected = next_rand();
    bus_write(addr, expected, 4'hf, 1'b0);
    for (int lane = 0; lane < 4; lane++) begin
      data = next_rand();
      bus_write(addr, data, 4'(1 << lane), 1'b0);
      expected[8*lane +: 8] = data[8*lane +: 8];
      bus_read(addr, 1'b0, rdata);
      check("cpu_rsp.rdata", expected, rdata);
    end
    bus_read(addr, 1'b1, rdata);
    check("cpu_rsp.rdata on fetch", expected, rdata);
    bus_write(addr, ~expected, 4'hf, 1'b1); // A fetch must not write.
    bus_read(addr, 1'b0, rdata);
    check("cpu_rsp.rdata after fetch", expected, rdata);
    ram_model[ram_index(addr)] = expected;
    finish_test("byte strobes and fetch", start);
  endtask

  task automatic test_decode_alias();
    logic [31:0] below;
    logic [31:0] data;
    logic [31:0] rdata;
    int start;
    start = errors;
    below = clint_base_address - 32'h1000;
    data = next_rand();
    bus_write(clint_top_address, data, 4'hf, 1'b0);
    ram_model[ram_index(clint_top_address)] = data;
    bus_read(below, 1'b0, rdata);
    check("cpu_rsp.rdata below window", ram_model[ram_index(below)], rdata);
    bus_read(32'(ram_index(clint_top_address)) * 32'd4, 1'b0, rdata);
    check("cpu_rsp.rdata aliased", data, rdata);
    finish_test("decode boundary and aliasing", start);
  endtask

  task automatic test_msip();
    logic [31:0] addr;
    logic [31:0] rdata;
    int start;
    start = errors;
    addr = clint_base_address + msip_offset + 32'd4; // Hart 1.
    bus_write(addr, 32'd1, 4'hf, 1'b0);
    check("msip", 32'b10, 32'(msip));
    bus_read(addr, 1'b0, rdata);
    check("cpu_rsp.rdata msip", 32'd1, rdata);
    bus_write(addr, 32'd0, 4'hf, 1'b0);
    check("msip", 32'd0, 32'(msip));
    finish_test("msip", start);
  endtask

  task automatic test_timer_compare();
    logic [31:0] time_addr;
    logic [31:0] cmp_addr;
    int cycles;
    int start;
    start = errors;
    time_addr = clint_base_address + mtime_offset;
    cmp_addr = clint_base_address + mtimecmp_offset; // Hart 0.
    bus_write(time_addr, 32'd0, 4'hf, 1'b0);
    bus_write(time_addr + 32'd4, 32'd0, 4'hf, 1'b0);
    bus_write(cmp_addr, 32'hffff_ffff, 4'hf, 1'b0);
    bus_write(cmp_addr + 32'd4, 32'hffff_ffff, 4'hf, 1'b0);
    repeat (3) @(negedge clk);
    check("mtip[0]", 32'd0, 32'(mtip[0]));
    bus_write(cmp_addr, 32'd0, 4'hf, 1'b0);
    bus_write(cmp_addr + 32'd4, 32'd0, 4'hf, 1'b0);
    cycles = 0;
    while (!mtip[0] && cycles < 32) begin
      @(negedge clk);
      cycles++;
    end
    if (!mtip[0]) begin
      $display("ERROR %0t: mtip of hart 0 did not rise after mtimecmp was cleared", $time);
      errors++;
    end
    check("mtip[1]", 32'd0, 32'(mtip[1]));
    finish_test("timer compare", start);
  endtask

  task automatic test_mtime_advance();
    logic [31:0] time_addr;
    logic [63:0] x;
    logic [63:0] bound;
    logic [31:0] lo;
    logic [31:0] hi;
    int rises_start;
    int start;
    start = errors;
    time_addr = clint_base_address + mtime_offset;
    x[63:32] = next_rand();
    x[31:0] = next_rand() & 32'h7fff_ffff; // No carry out of the low half.
    rises_start = rtc_rises;
    bus_write(time_addr, x[31:0], 4'hf, 1'b0);
    bus_write(time_addr + 32'd4, x[63:32], 4'hf, 1'b0);
    repeat (100) @(negedge clk);
    bus_read(time_addr, 1'b0, lo);
    bus_read(time_addr + 32'd4, 1'b0, hi);
    bound = x + 64'(rtc_rises - rises_start) + 64'd1;
    if ({hi, lo} < x || {hi, lo} > bound) begin
      $display("ERROR %0t: mtime read %h is outside %h to %h", $time, {hi, lo}, x, bound);
      errors++;
    end
    if (mtime < {hi, lo} || mtime > bound) begin
      $display("ERROR %0t: mtime port %h disagrees with read %h", $time, mtime, {hi, lo});
      errors++;
    end
    finish_test("mtime advance", start);
  endtask

  initial begin
    arst_n = 1'b0;
    cpu_req = '0;
    seed = 32'hf50e;
    errors = 0;
    tests_passed = 0;
    tests_failed = 0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    test_ram_readback();
    test_strobes_fetch();
    test_decode_alias();
    test_msip();
    test_timer_compare();
    test_mtime_advance();
    $display("tests: %0d ok, %0d failed, %0d errors", tests_passed, tests_failed, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* compile.f */
hdl/soc_pkg.sv
hdl/mem_decoder.sv
hdl/bram.sv
hdl/clint.sv
hdl/soc.sv
testbench/soc_tb.sv

/* Makefile */
TOP = soc_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -o $(TOP)
	@out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir
